// File: logic/merge_consts.svh
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// width of one data word. a zero word is the run terminator.
`define MERGE_WORD_W 16

// entries per input buffer.
// each upstream producer starts with this many credits.
`define MERGE_FIFO_DEPTH 8

// downstream receiver buffer size, credits held by the output stage after reset.
`define MERGE_OUT_CREDITS 4

`endif

// File: logic/merge_pkg.sv
`include "merge_consts.svh"

package merge_pkg;

   // one data word, zero marks the end of a run.
   typedef logic [`MERGE_WORD_W-1:0] word_t;

   // merge control state.
   typedef enum logic [1:0] {
      MERGE_BOTH,
      DRAIN_B,
      DRAIN_A
   } merge_state_e;

   // what the output stage emits this cycle.
   typedef enum logic [1:0] {
      PICK_NONE,
      PICK_A,
      PICK_B,
      PICK_TERM
   } merge_pick_e;

endpackage

// File: logic/run_fifo.sv
`include "merge_consts.svh"

module run_fifo
   import merge_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  logic  i_push,
   input  word_t i_data,
   input  logic  i_pop,
   output word_t o_data,
   output logic  o_empty
);

   localparam int DEPTH = `MERGE_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   word_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // storage, written on push only.
   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // pointers wrap at the buffer depth, which need not be a power of two.
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head falls through without a read cycle.
   assign o_data  = mem[rd_ptr];
   assign o_empty = (count == '0);

endmodule

// File: logic/merge_control.sv
`include "merge_consts.svh"

module merge_control
   import merge_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst,
   input  word_t       i_a_head,
   input  logic        i_a_empty,
   input  word_t       i_b_head,
   input  logic        i_b_empty,
   input  logic        i_can_emit,
   output merge_pick_e o_pick,
   output logic        o_pop_a,
   output logic        o_pop_b
);

   merge_state_e state;
   merge_state_e next_state;
   logic         a_term;
   logic         b_term;
   logic         a_lte_b;

   // a zero head is the end of the current run.
   assign a_term  = (i_a_head == '0);
   assign b_term  = (i_b_head == '0);
   assign a_lte_b = (i_a_head <= i_b_head);

   // every decision is taken in the same cycle it is seen.
   always_comb begin
      next_state = state;
      o_pick     = PICK_NONE;
      o_pop_a    = 1'b0;
      o_pop_b    = 1'b0;

      // nothing moves while downstream has no room.
      if (i_can_emit) begin
         case (state)
            MERGE_BOTH: begin
               if (!i_a_empty && !i_b_empty) begin
                  if (a_term) begin
                     // a terminator stays at the A head until B drains.
                     next_state = DRAIN_B;
                  end else if (b_term) begin
                     next_state = DRAIN_A;
                  end else if (a_lte_b) begin
                     // ties go to A.
                     o_pick  = PICK_A;
                     o_pop_a = 1'b1;
                  end else begin
                     o_pick  = PICK_B;
                     o_pop_b = 1'b1;
                  end
               end
            end

            DRAIN_B: begin
               if (!i_b_empty) begin
                  if (b_term) begin
                     // both runs done, close the merged run.
                     o_pick     = PICK_TERM;
                     o_pop_a    = 1'b1;
                     o_pop_b    = 1'b1;
                     next_state = MERGE_BOTH;
                  end else begin
                     o_pick  = PICK_B;
                     o_pop_b = 1'b1;
                  end
               end
            end

            DRAIN_A: begin
               if (!i_a_empty) begin
                  if (a_term) begin
                     o_pick     = PICK_TERM;
                     o_pop_a    = 1'b1;
                     o_pop_b    = 1'b1;
                     next_state = MERGE_BOTH;
                  end else begin
                     o_pick  = PICK_A;
                     o_pop_a = 1'b1;
                  end
               end
            end

            default: begin
               next_state = MERGE_BOTH;
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= MERGE_BOTH;
      end else begin
         state <= next_state;
      end
   end

endmodule

// File: logic/merge_output.sv
`include "merge_consts.svh"

module merge_output
   import merge_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst,
   input  merge_pick_e i_pick,
   input  word_t       i_a_head,
   input  word_t       i_b_head,
   input  logic        i_out_credit,
   output logic        o_can_emit,
   output logic        o_out_valid,
   output word_t       o_out_data
);

   localparam int CREDITS = `MERGE_OUT_CREDITS;
   localparam int CRED_W  = $clog2(CREDITS + 1);

   logic [CRED_W-1:0] credits;
   logic              emit;

   assign emit = (i_pick != PICK_NONE);

   // output word register.
   always_ff @(posedge i_clk) begin
      case (i_pick)
         PICK_A:  o_out_data <= i_a_head;
         PICK_B:  o_out_data <= i_b_head;
         default: o_out_data <= '0;
      endcase
   end

   // one emit spends a credit, each returned credit adds one back.
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_out_valid <= 1'b0;
         credits     <= CRED_W'(CREDITS);
      end else begin
         o_out_valid <= emit;
         case ({emit, i_out_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   assign o_can_emit = (credits != '0);

endmodule

// File: logic/merge_unit.sv
`include "merge_consts.svh"

module merge_unit
   import merge_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   // stream A, sent only against held credits.
   input  logic  i_a_valid,
   input  word_t i_a_data,
   output logic  o_a_credit,
   // stream B.
   input  logic  i_b_valid,
   input  word_t i_b_data,
   output logic  o_b_credit,
   // merged output, the receiver must take every valid word.
   output logic  o_out_valid,
   output word_t o_out_data,
   input  logic  i_out_credit
);

   word_t       a_head;
   word_t       b_head;
   logic        a_empty;
   logic        b_empty;
   logic        pop_a;
   logic        pop_b;
   logic        can_emit;
   merge_pick_e pick;

   run_fifo u_fifo_a (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_push  (i_a_valid),
      .i_data  (i_a_data),
      .i_pop   (pop_a),
      .o_data  (a_head),
      .o_empty (a_empty)
   );

   run_fifo u_fifo_b (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_push  (i_b_valid),
      .i_data  (i_b_data),
      .i_pop   (pop_b),
      .o_data  (b_head),
      .o_empty (b_empty)
   );

   merge_control u_control (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_a_head   (a_head),
      .i_a_empty  (a_empty),
      .i_b_head   (b_head),
      .i_b_empty  (b_empty),
      .i_can_emit (can_emit),
      .o_pick     (pick),
      .o_pop_a    (pop_a),
      .o_pop_b    (pop_b)
   );

   merge_output u_output (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_pick       (pick),
      .i_a_head     (a_head),
      .i_b_head     (b_head),
      .i_out_credit (i_out_credit),
      .o_can_emit   (can_emit),
      .o_out_valid  (o_out_valid),
      .o_out_data   (o_out_data)
   );

   // each pop frees one buffer slot upstream.
   assign o_a_credit = pop_a;
   assign o_b_credit = pop_b;

endmodule

// File: dv/merge_unit_tb.sv
`include "merge_consts.svh"

module merge_unit_tb
   import merge_pkg::*;
();

   logic  clk        = 1'b0;
   logic  rst;
   logic  a_valid    = 1'b0;
   word_t a_data     = '0;
   logic  a_credit;
   logic  b_valid    = 1'b0;
   word_t b_data     = '0;
   logic  b_credit;
   logic  out_valid;
   word_t out_data;
   logic  out_credit = 1'b0;

   word_t       a_q[$];
   word_t       b_q[$];
   word_t       exp_q[$];
   logic [31:0] seed = 32'h16ad_d32d;
   int          a_idx, b_idx, exp_idx;
   int          a_pulses, b_pulses;
   int          out_count, cred_returned;
   int          run_errors, end_errors;
   int          cycles, limit;

   merge_unit dut (
      .i_clk        (clk),
      .i_rst        (rst),
      .i_a_valid    (a_valid),
      .i_a_data     (a_data),
      .o_a_credit   (a_credit),
      .i_b_valid    (b_valid),
      .i_b_data     (b_data),
      .o_b_credit   (b_credit),
      .o_out_valid  (out_valid),
      .o_out_data   (out_data),
      .i_out_credit (out_credit)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // pops the merge rule asks for next, as {a, b}, given the next word of each run.
   function automatic logic [1:0] expected_pops(input word_t a_word, input word_t b_word);
      if (a_word == '0 && b_word == '0) begin
         return 2'b11;
      end else if (a_word == '0) begin
         return 2'b01;
      end else if (b_word == '0) begin
         return 2'b10;
      end else if (a_word <= b_word) begin
         return 2'b10;
      end else begin
         return 2'b01;
      end
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         run_errors++;
      end
   endtask

   task automatic check_pops(input string name, input logic [1:0] got,
                             input logic [1:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         run_errors++;
      end
   endtask

   task automatic check_pick_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         end_errors++;
      end
   endtask

   // lines are a one letter tag and a hex word, lines opening with # are skipped.
   task automatic load_stimulus();
      int         fd;
      int         n;
      int         c;
      logic [7:0] tag;
      word_t      w;
      fd = $fopen("dv/merge_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the data file dv/merge_input.txt");
         end_errors++;
         return;
      end
      n = $fscanf(fd, " %s", tag);
      while (n == 1) begin
         if (tag == "#") begin
            c = 0;
            while (c != 10 && c != -1) begin
               c = $fgetc(fd);
            end
         end else if ($fscanf(fd, " %h", w) != 1) begin
            $display("a tag in the data file has no word after it");
            end_errors++;
         end else begin
            case (tag)
               "A":     a_q.push_back(w);
               "B":     b_q.push_back(w);
               "E":     exp_q.push_back(w);
               default: begin
                  $display("the data file holds an unknown tag");
                  end_errors++;
               end
            endcase
         end
         n = $fscanf(fd, " %s", tag);
      end
      $fclose(fd);
   endtask

   // producers send with random gaps, only while a credit is held.
   always @(posedge clk) begin
      if (!rst) begin
         seed = lcg_next(seed);
         a_valid    <= 1'b0;
         b_valid    <= 1'b0;
         out_credit <= 1'b0;
         if (a_idx < a_q.size() && a_idx - a_pulses < `MERGE_FIFO_DEPTH &&
             seed[31:30] != 2'b00) begin
            a_valid <= 1'b1;
            a_data  <= a_q[a_idx];
            a_idx++;
         end
         if (b_idx < b_q.size() && b_idx - b_pulses < `MERGE_FIFO_DEPTH &&
             seed[29:28] != 2'b00) begin
            b_valid <= 1'b1;
            b_data  <= b_q[b_idx];
            b_idx++;
         end
         // slow receiver, frees a slot only for a word it already holds.
         if (out_count > cred_returned && seed[27:25] < 3'd3) begin
            out_credit <= 1'b1;
            cred_returned++;
         end
      end
   end

   // sampled away from the rising edge, where outputs are settled.
   always @(negedge clk) begin
      if (!rst) begin
         // the credit pulses show which heads were popped, so ties are visible here.
         if ((a_credit || b_credit) && a_pulses < a_q.size() &&
             b_pulses < b_q.size()) begin
            check_pops("o_a_credit o_b_credit", {a_credit, b_credit},
                       expected_pops(a_q[a_pulses], b_q[b_pulses]));
         end
         if (a_credit) begin
            a_pulses++;
         end
         if (b_credit) begin
            b_pulses++;
         end
         if (out_valid) begin
            if (exp_idx < exp_q.size()) begin
               check_word("o_out_data", out_data, exp_q[exp_idx]);
               exp_idx++;
            end else begin
               $display("output word %h arrived after the last expected word", out_data);
               run_errors++;
            end
            out_count++;
         end
         if (out_count > cred_returned + `MERGE_OUT_CREDITS) begin
            $display("more output words arrived than the returned credits allow");
            run_errors++;
         end
      end
   end

   initial begin
      rst = 1'b1;
      load_stimulus();
      limit = 20 * (a_q.size() + b_q.size() + exp_q.size()) + 200;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      while (a_idx < a_q.size() || b_idx < b_q.size() || exp_idx < exp_q.size() ||
             out_count > cred_returned) begin
         @(posedge clk);
      end
      // idle cycles catch a stray word or credit pulse.
      repeat (5) @(posedge clk);
      check_pick_count("o_a_credit pulses", a_pulses, a_q.size());
      check_pick_count("o_b_credit pulses", b_pulses, b_q.size());
      check_pick_count("a credit counter", `MERGE_FIFO_DEPTH - a_idx + a_pulses,
                       `MERGE_FIFO_DEPTH);
      check_pick_count("b credit counter", `MERGE_FIFO_DEPTH - b_idx + b_pulses,
                       `MERGE_FIFO_DEPTH);
      check_pick_count("o_out_valid words", out_count, exp_q.size());
      $display("words checked %0d, run errors %0d, end errors %0d, cycles %0d",
               out_count, run_errors, end_errors, cycles);
      if (run_errors == 0 && end_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // cycle limit scales with the amount of stimulus.
   initial begin
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

endmodule

// File: dv/merge_input.txt
# tag word: A and B are input words for that stream, E is an expected output word
# words are hex and a zero word ends a run
A 0003
A 0008
A 000f
A 0000
B 0001
B 0009
B 000f
B 0020
B 0000
E 0001
E 0003
E 0008
E 0009
E 000f
E 000f
E 0020
E 0000
A 0000
B 0005
B 0000
E 0005
E 0000
A 0007
A 0000
B 0000
E 0007
E 0000
A 0000
B 0000
E 0000
A 0002
A 0004
A 0000
B 0002
B 0004
B 0000
E 0002
E 0002
E 0004
E 0004
E 0000

// File: merge_unit.f
+incdir+logic
logic/merge_pkg.sv
logic/run_fifo.sv
logic/merge_control.sv
logic/merge_output.sv
logic/merge_unit.sv
dv/merge_unit_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := merge_unit_tb
FILELIST := merge_unit.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
